//--- logic/bridge_pkg.sv
// ---------------------------------------------------------------------
// bridge_pkg
// shared widths, channel ids, buffer depths and the link word format
// for the chip-to-FPGA link bridge
// ---------------------------------------------------------------------
`default_nettype none

package bridge_pkg;

    // three network channels share one link
    localparam int NUM_CHAN = 3;

    // send-side flit buffer depth per channel
    localparam int TX_DEPTH = 2;

    // receive-side buffer depth, also the starting credit count
    localparam int RX_DEPTH = 4;

    // wide enough to hold RX_DEPTH
    localparam int CREDIT_W = 3;

    // network flit and link word widths
    localparam int FLIT_W = 64;
    localparam int LINK_W = 32;
    localparam int CHAN_W = 2;

    typedef logic [FLIT_W-1:0]   flit_t;
    typedef logic [LINK_W-1:0]   link_data_t;

    // 0 is idle, 1..3 name the channels
    typedef logic [CHAN_W-1:0]   chan_id_t;

    // bit 0 goes with channel 1
    typedef logic [NUM_CHAN-1:0] credit_vec_t;

    typedef logic [CREDIT_W-1:0] credit_cnt_t;

    // no word on the link this cycle
    localparam chan_id_t CHAN_IDLE = '0;

    // one interconnect beat, 34 bits
    typedef struct packed {
        chan_id_t   channel;
        link_data_t data;
    } link_word_t;

endpackage

`default_nettype wire

//--- logic/flit_fifo.sv
// ---------------------------------------------------------------------
// flit_fifo
// synchronous circular flit buffer, valid/ready on both sides
// ---------------------------------------------------------------------
`default_nettype none

module flit_fifo #(
    parameter int DEPTH = 2
) (
    input  logic              fpga_clk,
    input  logic              rst_n,
    input  bridge_pkg::flit_t in_data,
    input  logic              in_val,
    output logic              in_rdy,
    output bridge_pkg::flit_t out_data,
    output logic              out_val,
    input  logic              out_rdy
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    bridge_pkg::flit_t mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              do_wr;
    logic              do_rd;

    // pointer step with wrap at DEPTH
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    assign out_val = (count != '0);
    // a full buffer still takes a flit when it is popped this cycle
    assign in_rdy  = !full || out_rdy;
    assign do_rd   = out_val && out_rdy;
    assign do_wr   = in_val && in_rdy;

    // head flit, visible the cycle after its write
    assign out_data = mem[rd_ptr];

    // storage
    always_ff @(posedge fpga_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers and occupancy
    always_ff @(posedge fpga_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // simultaneous push and pop keeps the count
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/bridge_send.sv
// ---------------------------------------------------------------------
// bridge_send
// buffers outgoing flits per channel, picks a channel round-robin
// among those with a flit and a credit, sends each flit as two words
// ---------------------------------------------------------------------
`default_nettype none

module bridge_send (
    input  logic                    fpga_clk,
    input  logic                    rst_n,
    input  bridge_pkg::flit_t       out_flit [bridge_pkg::NUM_CHAN],
    input  logic                    out_val  [bridge_pkg::NUM_CHAN],
    output logic                    out_rdy  [bridge_pkg::NUM_CHAN],
    output bridge_pkg::link_word_t  link_out,
    input  bridge_pkg::credit_vec_t credit_in
);

    typedef enum logic {
        st_idle,
        st_low_half
    } send_state_t;

    send_state_t               state;
    bridge_pkg::flit_t         q_flit [bridge_pkg::NUM_CHAN];
    logic                      q_val  [bridge_pkg::NUM_CHAN];
    logic                      q_pop  [bridge_pkg::NUM_CHAN];
    bridge_pkg::credit_cnt_t   credit_cnt [bridge_pkg::NUM_CHAN];
    logic [bridge_pkg::NUM_CHAN-1:0] eligible;

    // last channel served, as an array index
    logic [1:0]                rr_last;
    logic [1:0]                pick_idx;
    logic                      pick_any;
    bridge_pkg::flit_t         sel_flit;

    // lower half waiting for the second beat
    bridge_pkg::chan_id_t      low_chan;
    bridge_pkg::link_data_t    low_data;

    // index step modulo NUM_CHAN
    function automatic logic [1:0] wrap_add(input logic [1:0] base, input int step);
        int sum;
        sum = int'(base) + step;
        if (sum >= bridge_pkg::NUM_CHAN) begin
            sum = sum - bridge_pkg::NUM_CHAN;
        end
        return 2'(sum);
    endfunction

    for (genvar g = 0; g < bridge_pkg::NUM_CHAN; g++) begin : g_chan
        flit_fifo #(
            .DEPTH (bridge_pkg::TX_DEPTH)
        ) u_txq (
            .fpga_clk (fpga_clk),
            .rst_n    (rst_n),
            .in_data  (out_flit[g]),
            .in_val   (out_val[g]),
            .in_rdy   (out_rdy[g]),
            .out_data (q_flit[g]),
            .out_val  (q_val[g]),
            .out_rdy  (q_pop[g])
        );

        // needs a flit and room at the far end
        assign eligible[g] = q_val[g] && (credit_cnt[g] != '0);

        // pop as the upper half is launched
        assign q_pop[g] = (state == st_idle) && pick_any && (pick_idx == 2'(g));

        // credit counter, starts full
        always_ff @(posedge fpga_clk) begin
            if (!rst_n) begin
                credit_cnt[g] <= bridge_pkg::CREDIT_W'(bridge_pkg::RX_DEPTH);
            end else if (q_pop[g] && !credit_in[g]) begin
                credit_cnt[g] <= credit_cnt[g] - 1'b1;
            end else if (credit_in[g] && !q_pop[g]) begin
                credit_cnt[g] <= credit_cnt[g] + 1'b1;
            end
        end
    end

    // round-robin choice, nearest eligible after rr_last wins
    always_comb begin
        pick_any = 1'b0;
        pick_idx = rr_last;
        sel_flit = q_flit[0];
        // walk far to near so the nearest hit is written last
        for (int i = bridge_pkg::NUM_CHAN; i >= 1; i--) begin
            if (eligible[wrap_add(rr_last, i)]) begin
                pick_any = 1'b1;
                pick_idx = wrap_add(rr_last, i);
            end
        end
        for (int c = 0; c < bridge_pkg::NUM_CHAN; c++) begin
            if (pick_idx == 2'(c)) begin
                sel_flit = q_flit[c];
            end
        end
    end

    // serializer, upper half then lower half back to back
    always_ff @(posedge fpga_clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            rr_last  <= 2'(bridge_pkg::NUM_CHAN - 1);
            link_out <= '0;
            low_chan <= bridge_pkg::CHAN_IDLE;
        end else begin
            case (state)
                st_idle: begin
                    if (pick_any) begin
                        link_out.channel <= bridge_pkg::chan_id_t'(pick_idx + 2'd1);
                        link_out.data    <= sel_flit[bridge_pkg::FLIT_W-1 -: bridge_pkg::LINK_W];
                        low_chan         <= bridge_pkg::chan_id_t'(pick_idx + 2'd1);
                        rr_last          <= pick_idx;
                        state            <= st_low_half;
                    end else begin
                        // idle beat
                        link_out <= '0;
                    end
                end
                st_low_half: begin
                    link_out.channel <= low_chan;
                    link_out.data    <= low_data;
                    state            <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // lower half payload
    always_ff @(posedge fpga_clk) begin
        if (state == st_idle && pick_any) begin
            low_data <= sel_flit[bridge_pkg::LINK_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- logic/bridge_rcv.sv
// ---------------------------------------------------------------------
// bridge_rcv
// reassembles link word pairs into flits, buffers them per channel
// and returns one credit per flit taken at the network side
// ---------------------------------------------------------------------
`default_nettype none

module bridge_rcv (
    input  logic                    fpga_clk,
    input  logic                    rst_n,
    input  bridge_pkg::link_word_t  link_in,
    output bridge_pkg::flit_t       in_flit [bridge_pkg::NUM_CHAN],
    output logic                    in_val  [bridge_pkg::NUM_CHAN],
    input  logic                    in_rdy  [bridge_pkg::NUM_CHAN],
    output bridge_pkg::credit_vec_t credit_out
);

    // 0 waits for an upper half, 1 for a lower half
    logic                            phase;
    logic                            word_val;

    // upper half held between the two beats
    bridge_pkg::link_data_t          hi_data;
    bridge_pkg::chan_id_t            hi_chan;

    // assembled flit, one stage before the buffers
    bridge_pkg::flit_t               wr_flit;
    logic [bridge_pkg::NUM_CHAN-1:0] wr_val;

    assign word_val = (link_in.channel != bridge_pkg::CHAN_IDLE);

    // phase tracking and buffer select
    always_ff @(posedge fpga_clk) begin
        if (!rst_n) begin
            phase   <= 1'b0;
            hi_chan <= bridge_pkg::CHAN_IDLE;
            wr_val  <= '0;
        end else begin
            wr_val <= '0;
            if (word_val) begin
                if (!phase) begin
                    phase   <= 1'b1;
                    hi_chan <= link_in.channel;
                end else begin
                    phase <= 1'b0;
                    // route by the channel of the upper half
                    for (int c = 0; c < bridge_pkg::NUM_CHAN; c++) begin
                        wr_val[c] <= (hi_chan == bridge_pkg::chan_id_t'(c + 1));
                    end
                end
            end
        end
    end

    // payload capture
    always_ff @(posedge fpga_clk) begin
        if (word_val && !phase) begin
            hi_data <= link_in.data;
        end
        if (word_val && phase) begin
            wr_flit <= {hi_data, link_in.data};
        end
    end

    for (genvar g = 0; g < bridge_pkg::NUM_CHAN; g++) begin : g_chan
        // room is guaranteed by the sender's credits
        flit_fifo #(
            .DEPTH (bridge_pkg::RX_DEPTH)
        ) u_rxq (
            .fpga_clk (fpga_clk),
            .rst_n    (rst_n),
            .in_data  (wr_flit),
            .in_val   (wr_val[g]),
            .in_rdy   (),
            .out_data (in_flit[g]),
            .out_val  (in_val[g]),
            .out_rdy  (in_rdy[g])
        );

        // one pulse per flit leaving the buffer
        assign credit_out[g] = in_val[g] && in_rdy[g];
    end

endmodule

`default_nettype wire

//--- logic/fpga_bridge.sv
// ---------------------------------------------------------------------
// fpga_bridge
// top level, send and receive halves side by side on one clock
// ---------------------------------------------------------------------
`default_nettype none

module fpga_bridge (
    input  logic                    rst_n,
    input  logic                    fpga_clk,
    input  bridge_pkg::flit_t       network_out_1,
    input  bridge_pkg::flit_t       network_out_2,
    input  bridge_pkg::flit_t       network_out_3,
    input  logic                    data_out_val_1,
    input  logic                    data_out_val_2,
    input  logic                    data_out_val_3,
    output logic                    data_out_rdy_1,
    output logic                    data_out_rdy_2,
    output logic                    data_out_rdy_3,
    input  bridge_pkg::link_data_t  intcnct_data_in,
    input  bridge_pkg::chan_id_t    intcnct_channel_in,
    output bridge_pkg::credit_vec_t intcnct_credit_back_in,
    output bridge_pkg::flit_t       network_in_1,
    output bridge_pkg::flit_t       network_in_2,
    output bridge_pkg::flit_t       network_in_3,
    output logic                    data_in_val_1,
    output logic                    data_in_val_2,
    output logic                    data_in_val_3,
    input  logic                    data_in_rdy_1,
    input  logic                    data_in_rdy_2,
    input  logic                    data_in_rdy_3,
    output bridge_pkg::link_data_t  intcnct_data_out,
    output bridge_pkg::chan_id_t    intcnct_channel_out,
    input  bridge_pkg::credit_vec_t intcnct_credit_back_out
);

    // network-to-link direction
    bridge_pkg::flit_t      send_flit [bridge_pkg::NUM_CHAN];
    logic                   send_val  [bridge_pkg::NUM_CHAN];
    logic                   send_rdy  [bridge_pkg::NUM_CHAN];
    bridge_pkg::link_word_t link_out;

    // link-to-network direction
    bridge_pkg::flit_t      rcv_flit [bridge_pkg::NUM_CHAN];
    logic                   rcv_val  [bridge_pkg::NUM_CHAN];
    logic                   rcv_rdy  [bridge_pkg::NUM_CHAN];
    bridge_pkg::link_word_t link_in;

    // flat ports to per-channel arrays, index 0 is channel 1
    assign send_flit[0]   = network_out_1;
    assign send_flit[1]   = network_out_2;
    assign send_flit[2]   = network_out_3;
    assign send_val[0]    = data_out_val_1;
    assign send_val[1]    = data_out_val_2;
    assign send_val[2]    = data_out_val_3;
    assign data_out_rdy_1 = send_rdy[0];
    assign data_out_rdy_2 = send_rdy[1];
    assign data_out_rdy_3 = send_rdy[2];

    assign network_in_1   = rcv_flit[0];
    assign network_in_2   = rcv_flit[1];
    assign network_in_3   = rcv_flit[2];
    assign data_in_val_1  = rcv_val[0];
    assign data_in_val_2  = rcv_val[1];
    assign data_in_val_3  = rcv_val[2];
    assign rcv_rdy[0]     = data_in_rdy_1;
    assign rcv_rdy[1]     = data_in_rdy_2;
    assign rcv_rdy[2]     = data_in_rdy_3;

    // link word split and join
    assign intcnct_data_out    = link_out.data;
    assign intcnct_channel_out = link_out.channel;
    assign link_in             = {intcnct_channel_in, intcnct_data_in};

    bridge_send u_send (
        .fpga_clk  (fpga_clk),
        .rst_n     (rst_n),
        .out_flit  (send_flit),
        .out_val   (send_val),
        .out_rdy   (send_rdy),
        .link_out  (link_out),
        .credit_in (intcnct_credit_back_out)
    );

    bridge_rcv u_rcv (
        .fpga_clk   (fpga_clk),
        .rst_n      (rst_n),
        .link_in    (link_in),
        .in_flit    (rcv_flit),
        .in_val     (rcv_val),
        .in_rdy     (rcv_rdy),
        .credit_out (intcnct_credit_back_in)
    );

endmodule

`default_nettype wire

//--- test/tb_fpga_bridge.sv
// ----------------------------------------------------------------------
// tb_fpga_bridge
// loopback testbench for the link bridge, link words and credits are
// fed straight back, per-channel scoreboards and concurrent checks
// ----------------------------------------------------------------------
`default_nettype none

module tb_fpga_bridge;

    // 3 x (1 + 200 + 60) flits at two link beats each is about 1600 cycles
    // with free flow, random ready and the stall stretch stay far below this
    localparam int MAX_CYCLES   = 20000;
    localparam int RAND_FLITS   = 200;
    localparam int STALL_FLITS  = 60;
    localparam int MOVE_FLITS   = 20;
    localparam int INFLIGHT_MAX = bridge_pkg::RX_DEPTH + bridge_pkg::TX_DEPTH;
    localparam int NCH          = bridge_pkg::NUM_CHAN;

    logic fpga_clk;
    logic rst_n;

    // network side, index 0 is channel 1
    bridge_pkg::flit_t drv_flit [NCH];
    logic              drv_val  [NCH];
    logic              acc_rdy  [NCH];
    bridge_pkg::flit_t got_flit [NCH];
    logic              got_val  [NCH];
    logic              drv_rdy  [NCH];

    // looped-back interconnect
    bridge_pkg::link_data_t  link_data;
    bridge_pkg::chan_id_t    link_chan;
    bridge_pkg::credit_vec_t credit;

    // stimulus controls, percent chances
    integer seed;
    int     val_pct;
    int     rdy_pct [NCH];
    int     target  [NCH];

    // bookkeeping
    int                   accepted  [NCH];
    int                   delivered [NCH];
    int                   credits   [NCH];
    int                   cycle_cnt;
    bridge_pkg::flit_t    sb_q      [NCH][$];
    bridge_pkg::flit_t    link_q    [NCH][$];
    bridge_pkg::flit_t    exp_head  [NCH];
    logic                 exp_avail [NCH];
    bridge_pkg::flit_t    link_head [NCH];
    logic                 link_avail [NCH];
    logic                 link_phase;
    bridge_pkg::chan_id_t link_prev;
    int                   mark_1;
    int                   mark_3;

    fpga_bridge dut0 (
        .rst_n                   (rst_n),
        .fpga_clk                (fpga_clk),
        .network_out_1           (drv_flit[0]),
        .network_out_2           (drv_flit[1]),
        .network_out_3           (drv_flit[2]),
        .data_out_val_1          (drv_val[0]),
        .data_out_val_2          (drv_val[1]),
        .data_out_val_3          (drv_val[2]),
        .data_out_rdy_1          (acc_rdy[0]),
        .data_out_rdy_2          (acc_rdy[1]),
        .data_out_rdy_3          (acc_rdy[2]),
        .intcnct_data_in         (link_data),
        .intcnct_channel_in      (link_chan),
        .intcnct_credit_back_in  (credit),
        .network_in_1            (got_flit[0]),
        .network_in_2            (got_flit[1]),
        .network_in_3            (got_flit[2]),
        .data_in_val_1           (got_val[0]),
        .data_in_val_2           (got_val[1]),
        .data_in_val_3           (got_val[2]),
        .data_in_rdy_1           (drv_rdy[0]),
        .data_in_rdy_2           (drv_rdy[1]),
        .data_in_rdy_3           (drv_rdy[2]),
        .intcnct_data_out        (link_data),
        .intcnct_channel_out     (link_chan),
        .intcnct_credit_back_out (credit)
    );

    initial begin
        fpga_clk = 1'b0;
        forever #2 fpga_clk = ~fpga_clk;
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string why);
        $display("ERROR t=%0t %s", $time, why);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
        abort_run();
    endtask

    // channel tag and sequence number up top, random low word
    function automatic bridge_pkg::flit_t make_flit(input int chan, input int seq);
        logic [31:0] rnd;
        rnd = $random(seed);
        return {8'(chan + 1), 24'(seq), rnd};
    endfunction

    task automatic wait_drained();
        bit done;
        done = 1'b0;
        while (!done) begin
            @(posedge fpga_clk);
            done = 1'b1;
            for (int c = 0; c < NCH; c++) begin
                if (delivered[c] != target[c]) begin
                    done = 1'b0;
                end
            end
        end
    endtask

    // drivers, scoreboards and link tracking on one edge
    always @(posedge fpga_clk) begin
        logic        take_in;
        logic        take_out;
        int          n_acc;
        int          idx;
        logic [31:0] rnd;
        // lower half closes a link pair
        if (link_chan != bridge_pkg::CHAN_IDLE) begin
            if (link_phase) begin
                idx = int'(link_prev) - 1;
                if (link_q[idx].size() != 0) begin
                    link_q[idx].pop_front();
                end
            end
            link_phase <= !link_phase;
            link_prev  <= link_chan;
        end
        for (int c = 0; c < NCH; c++) begin
            take_in  = drv_val[c] && acc_rdy[c];
            take_out = got_val[c] && drv_rdy[c];
            if (take_in) begin
                sb_q[c].push_back(drv_flit[c]);
                link_q[c].push_back(drv_flit[c]);
                accepted[c] <= accepted[c] + 1;
            end
            if (take_out && sb_q[c].size() != 0) begin
                sb_q[c].pop_front();
            end
            if (take_out) begin
                delivered[c] <= delivered[c] + 1;
            end
            if (credit[c]) begin
                credits[c] <= credits[c] + 1;
            end
            n_acc = accepted[c] + int'(take_in);
            if (rst_n) begin
                // an offer holds until taken
                if (!drv_val[c] || acc_rdy[c]) begin
                    rnd = $random(seed);
                    if (n_acc < target[c] && (rnd % 100) < val_pct) begin
                        drv_val[c]  <= 1'b1;
                        drv_flit[c] <= make_flit(c, n_acc);
                    end else begin
                        drv_val[c] <= 1'b0;
                    end
                end
                rnd = $random(seed);
                drv_rdy[c] <= (rnd % 100) < rdy_pct[c];
            end
            exp_avail[c]  <= (sb_q[c].size() != 0);
            exp_head[c]   <= (sb_q[c].size() != 0) ? sb_q[c][0] : '0;
            link_avail[c] <= (link_q[c].size() != 0);
            link_head[c]  <= (link_q[c].size() != 0) ? link_q[c][0] : '0;
        end
    end

    // run limit
    always @(posedge fpga_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            report_error($sformatf("timeout, run still busy after %0d cycles", MAX_CYCLES));
        end
    end

    // outputs idle right after reset, inputs ready
    a_reset: assert property (@(posedge fpga_clk) $rose(rst_n) |->
        (!got_val[0] && !got_val[1] && !got_val[2] && link_chan == bridge_pkg::CHAN_IDLE
         && credit == '0 && acc_rdy[0] && acc_rdy[1] && acc_rdy[2]))
        else report_error("outputs not in their idle state after reset");

    // second beat follows at once on the same channel
    a_pair: assert property (@(posedge fpga_clk) disable iff (!rst_n)
        link_phase |-> (link_chan == link_prev))
        else report_mismatch("intcnct_channel_out", 64'($sampled(link_prev)),
                             64'($sampled(link_chan)));

    for (genvar g = 0; g < NCH; g++) begin : g_chk
        localparam bridge_pkg::chan_id_t CH = bridge_pkg::chan_id_t'(g + 1);

        a_known: assert property (@(posedge fpga_clk) disable iff (!rst_n)
            (got_val[g] && drv_rdy[g]) |-> exp_avail[g])
            else report_error($sformatf("flit on network_in_%0d that was never sent", g + 1));

        a_flit: assert property (@(posedge fpga_clk) disable iff (!rst_n)
            (got_val[g] && drv_rdy[g] && exp_avail[g]) |-> (got_flit[g] == exp_head[g]))
            else report_mismatch($sformatf("network_in_%0d", g + 1),
                                 $sampled(exp_head[g]), $sampled(got_flit[g]));

        // held while stalled by data_in_rdy
        a_hold: assert property (@(posedge fpga_clk) disable iff (!rst_n)
            ($past(got_val[g]) && !$past(drv_rdy[g])) |->
            (got_val[g] && got_flit[g] == $past(got_flit[g])))
            else report_error($sformatf("network_in_%0d or its valid moved under stall", g + 1));

        a_upper: assert property (@(posedge fpga_clk) disable iff (!rst_n)
            (!link_phase && link_chan == CH) |->
            (link_avail[g] && link_data == link_head[g][63:32]))
            else report_mismatch("intcnct_data_out upper", 64'($sampled(link_head[g][63:32])),
                                 64'($sampled(link_data)));

        a_lower: assert property (@(posedge fpga_clk) disable iff (!rst_n)
            (link_phase && link_prev == CH) |-> (link_data == link_head[g][31:0]))
            else report_mismatch("intcnct_data_out lower", 64'($sampled(link_head[g][31:0])),
                                 64'($sampled(link_data)));

        a_inflight: assert property (@(posedge fpga_clk) disable iff (!rst_n)
            (accepted[g] - delivered[g]) <= INFLIGHT_MAX)
            else report_error($sformatf("too many flits in flight on channel %0d", g + 1));
    end

    initial begin
        seed       = 32'hb9e3;
        rst_n      = 1'b0;
        val_pct    = 0;
        cycle_cnt  = 0;
        link_phase = 1'b0;
        link_prev  = bridge_pkg::CHAN_IDLE;
        for (int c = 0; c < NCH; c++) begin
            drv_flit[c]   = '0;
            drv_val[c]    = 1'b0;
            drv_rdy[c]    = 1'b0;
            rdy_pct[c]    = 0;
            target[c]     = 0;
            accepted[c]   = 0;
            delivered[c]  = 0;
            credits[c]    = 0;
            exp_avail[c]  = 1'b0;
            exp_head[c]   = '0;
            link_avail[c] = 1'b0;
            link_head[c]  = '0;
        end
        repeat (4) @(posedge fpga_clk);
        rst_n <= 1'b1;

        // one flit per channel in turn
        val_pct <= 100;
        for (int c = 0; c < NCH; c++) begin
            rdy_pct[c] <= 100;
        end
        for (int c = 0; c < NCH; c++) begin
            target[c] <= target[c] + 1;
            wait_drained();
        end

        // random traffic on all channels
        val_pct <= 60;
        for (int c = 0; c < NCH; c++) begin
            rdy_pct[c] <= 60;
            target[c]  <= target[c] + RAND_FLITS;
        end
        wait_drained();

        // channel 2 stalled at the network output
        val_pct    <= 100;
        rdy_pct[0] <= 100;
        rdy_pct[1] <= 0;
        rdy_pct[2] <= 100;
        for (int c = 0; c < NCH; c++) begin
            target[c] <= target[c] + STALL_FLITS;
        end
        do begin
            @(posedge fpga_clk);
        end while (acc_rdy[1]);
        mark_1 = delivered[0];
        mark_3 = delivered[2];
        while (delivered[0] < mark_1 + MOVE_FLITS || delivered[2] < mark_3 + MOVE_FLITS) begin
            @(posedge fpga_clk);
        end
        // credits gone and send buffer full by now
        a_stuck: assert (!acc_rdy[1])
            else report_error("data_out_rdy_2 high while channel 2 has no credit");
        rdy_pct[1] <= 100;
        wait_drained();

        // one credit pulse per flit taken
        for (int c = 0; c < NCH; c++) begin
            a_credits: assert (credits[c] == delivered[c])
                else report_mismatch($sformatf("intcnct_credit_back_in[%0d]", c),
                                     64'(delivered[c]), 64'(credits[c]));
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- fpga_bridge.f
logic/bridge_pkg.sv
logic/flit_fifo.sv
logic/bridge_send.sv
logic/bridge_rcv.sv
logic/fpga_bridge.sv
test/tb_fpga_bridge.sv

//--- Makefile
# Verilator build for the fpga_bridge loopback testbench
# any variable can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_fpga_bridge
FILELIST  ?= fpga_bridge.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the pass or fail result
sim: build
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
